// ==== Bender.yml ====
package:
  name: ip_eth_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/eth_ip_pkg.sv
      - hw/ip_rx_pkg.sv
      - hw/ip_hdr_capture.sv
      - hw/ip_hdr_checksum.sv
      - hw/payload_realign.sv
      - hw/ip_rx_fsm.sv
      - hw/stream_skid_reg.sv
      - hw/ip_eth_rx.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ip_eth_rx.sv

// ==== hw/eth_ip_pkg.sv ====
package eth_ip_pkg;

    // ethernet header, fields in wire order
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // ipv4 header without options, 20 bytes
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        // total length incl. header
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

endpackage

// ==== hw/ip_eth_rx.sv ====
`timescale 1ns/10ps

`include "ip_rx_settings.svh"

module ip_eth_rx
    import eth_ip_pkg::*;
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_hdr_valid,
    output logic       s_hdr_ready,
    input  eth_hdr_t   s_hdr,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    input  axis_beat_t s_payload,
    output logic       m_hdr_valid,
    input  logic       m_hdr_ready,
    output eth_hdr_t   m_eth,
    output ip_hdr_t    m_ip,
    output logic       m_payload_valid,
    input  logic       m_payload_ready,
    output axis_beat_t m_payload,
    output logic       busy,
    output rx_err_t    err
);

    logic                        store_eth;
    logic [`IP_RX_HDR_BEATS-1:0] hdr_beat_strobe;
    logic                        hdr_unsupported;
    logic                        csum_done;
    logic                        csum_ok;
    axis_beat_t                  shift_beat;
    logic                        shift_valid;
    logic                        realign_in_ready;
    logic                        realign_take;
    logic                        realign_flush;
    axis_beat_t                  int_beat;
    logic                        int_valid;
    logic                        skid_ready_early;
    logic                        skid_ready_int;

    ip_rx_fsm i_fsm (
        .clk              (clk),
        .rst              (rst),
        .s_hdr_valid      (s_hdr_valid),
        .s_payload_valid  (s_payload_valid),
        .s_payload_last   (s_payload.last),
        .hdr_unsupported  (hdr_unsupported),
        .csum_done        (csum_done),
        .csum_ok          (csum_ok),
        .shift_beat       (shift_beat),
        .shift_valid      (shift_valid),
        .realign_in_ready (realign_in_ready),
        .skid_ready_early (skid_ready_early),
        .skid_ready_int   (skid_ready_int),
        .m_hdr_ready      (m_hdr_ready),
        .s_hdr_ready      (s_hdr_ready),
        .s_payload_ready  (s_payload_ready),
        .store_eth        (store_eth),
        .hdr_beat_strobe  (hdr_beat_strobe),
        .realign_take     (realign_take),
        .realign_flush    (realign_flush),
        .int_beat         (int_beat),
        .int_valid        (int_valid),
        .m_hdr_valid      (m_hdr_valid),
        .busy             (busy),
        .err              (err)
    );

    ip_hdr_capture i_capture (
        .clk             (clk),
        .s_hdr           (s_hdr),
        .store_eth       (store_eth),
        .beat_data       (s_payload.data),
        .hdr_beat_strobe (hdr_beat_strobe),
        .m_eth           (m_eth),
        .m_ip            (m_ip),
        .hdr_unsupported (hdr_unsupported)
    );

    ip_hdr_checksum i_checksum (
        .clk             (clk),
        .rst             (rst),
        .beat_data       (s_payload.data),
        .hdr_beat_strobe (hdr_beat_strobe),
        .csum_done       (csum_done),
        .csum_ok         (csum_ok)
    );

    payload_realign i_realign (
        .clk             (clk),
        .rst             (rst),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .realign_take    (realign_take),
        .realign_flush   (realign_flush),
        .shift_beat      (shift_beat),
        .shift_valid     (shift_valid),
        .in_ready        (realign_in_ready)
    );

    stream_skid_reg i_skid (
        .clk             (clk),
        .rst             (rst),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .ready_early     (skid_ready_early),
        .ready_int       (skid_ready_int),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

// ==== hw/ip_hdr_capture.sv ====
`timescale 1ns/10ps

`include "ip_rx_settings.svh"

module ip_hdr_capture
    import eth_ip_pkg::*;
(
    input  logic                        clk,
    input  eth_hdr_t                    s_hdr,
    input  logic                        store_eth,
    input  logic [`IP_RX_DATA_W-1:0]    beat_data,
    input  logic [`IP_RX_HDR_BEATS-1:0] hdr_beat_strobe,
    output eth_hdr_t                    m_eth,
    output ip_hdr_t                     m_ip,
    output logic                        hdr_unsupported
);

    // network byte order, first byte is the msb
    function automatic logic [15:0] be16(input logic [15:0] b);
        return {b[7:0], b[15:8]};
    endfunction

    function automatic logic [31:0] be32(input logic [31:0] b);
        return {b[7:0], b[15:8], b[23:16], b[31:24]};
    endfunction

    always_ff @(posedge clk) begin
        if (store_eth) begin
            m_eth <= s_hdr;
        end
        // header bytes 0..7
        if (hdr_beat_strobe[0]) begin
            {m_ip.version, m_ip.ihl} <= beat_data[7:0];
            {m_ip.dscp, m_ip.ecn} <= beat_data[15:8];
            m_ip.length <= be16(beat_data[31:16]);
            m_ip.identification <= be16(beat_data[47:32]);
            {m_ip.flags, m_ip.frag_offset} <= be16(beat_data[63:48]);
        end
        // header bytes 8..15
        if (hdr_beat_strobe[1]) begin
            m_ip.ttl <= beat_data[7:0];
            m_ip.protocol <= beat_data[15:8];
            m_ip.hdr_checksum <= be16(beat_data[31:16]);
            m_ip.src_ip <= be32(beat_data[63:32]);
        end
        // bytes 16..19, upper half is payload
        if (hdr_beat_strobe[2]) begin
            m_ip.dest_ip <= be32(beat_data[31:0]);
        end
    end

    assign hdr_unsupported = (m_ip.version != 4'(`IP_RX_VERSION)) ||
                             (m_ip.ihl != 4'(`IP_RX_IHL));

endmodule

// ==== hw/ip_hdr_checksum.sv ====
`timescale 1ns/10ps

`include "ip_rx_settings.svh"

module ip_hdr_checksum (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`IP_RX_DATA_W-1:0]    beat_data,
    input  logic [`IP_RX_HDR_BEATS-1:0] hdr_beat_strobe,
    output logic                        csum_done,
    output logic                        csum_ok
);

    // ten 16-bit words fit in 20 bits
    logic [19:0] sum;
    logic [16:0] lo_sum;
    logic [16:0] hi_sum;
    logic [16:0] fold_a;
    logic [15:0] fold_b;

    assign lo_sum = 17'(beat_data[15:0]) + 17'(beat_data[31:16]);
    assign hi_sum = 17'(beat_data[47:32]) + 17'(beat_data[63:48]);

    always_ff @(posedge clk) begin
        if (rst) begin
            csum_done <= 1'b0;
        end else begin
            csum_done <= hdr_beat_strobe[2];
        end
    end

    // last beat only holds two header words
    always_ff @(posedge clk) begin
        if (hdr_beat_strobe[0]) begin
            sum <= 20'(lo_sum) + 20'(hi_sum);
        end else if (hdr_beat_strobe[1]) begin
            sum <= sum + 20'(lo_sum) + 20'(hi_sum);
        end else if (hdr_beat_strobe[2]) begin
            sum <= sum + 20'(lo_sum);
        end
    end

    // end-around carry, second fold catches the carry of the first
    assign fold_a = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold_b = fold_a[15:0] + 16'(fold_a[16]);
    assign csum_ok = (fold_b == 16'hffff);

endmodule

// ==== hw/ip_rx_fsm.sv ====
`timescale 1ns/10ps

`include "ip_rx_settings.svh"

module ip_rx_fsm
    import ip_rx_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s_hdr_valid,
    input  logic                        s_payload_valid,
    input  logic                        s_payload_last,
    input  logic                        hdr_unsupported,
    input  logic                        csum_done,
    input  logic                        csum_ok,
    input  axis_beat_t                  shift_beat,
    input  logic                        shift_valid,
    input  logic                        realign_in_ready,
    input  logic                        skid_ready_early,
    input  logic                        skid_ready_int,
    input  logic                        m_hdr_ready,
    output logic                        s_hdr_ready,
    output logic                        s_payload_ready,
    output logic                        store_eth,
    output logic [`IP_RX_HDR_BEATS-1:0] hdr_beat_strobe,
    output logic                        realign_take,
    output logic                        realign_flush,
    output axis_beat_t                  int_beat,
    output logic                        int_valid,
    output logic                        m_hdr_valid,
    output logic                        busy,
    output rx_err_t                     err
);

    localparam logic [1:0] HDR_LAST = 2'(`IP_RX_HDR_BEATS - 1);

    rx_state_e  state;
    rx_state_e  state_next;
    logic [1:0] hdr_cnt;
    logic [1:0] hdr_cnt_next;
    logic       s_hdr_ready_next;
    logic       s_payload_ready_next;
    logic       m_hdr_valid_next;
    rx_err_t    err_next;
    logic       in_xfer;
    logic       fwd;

    assign in_xfer = s_payload_ready && s_payload_valid;
    assign fwd = skid_ready_int && shift_valid;

    always_comb begin
        state_next = state;
        hdr_cnt_next = hdr_cnt;
        s_payload_ready_next = 1'b0;
        m_hdr_valid_next = m_hdr_valid && !m_hdr_ready;
        err_next = '0;
        store_eth = 1'b0;
        hdr_beat_strobe = '0;
        realign_take = 1'b0;
        realign_flush = 1'b0;
        int_valid = 1'b0;

        case (state)
            IDLE: begin
                hdr_cnt_next = '0;
                realign_flush = 1'b1;
                if (s_hdr_ready && s_hdr_valid) begin
                    store_eth = 1'b1;
                    s_payload_ready_next = 1'b1;
                    state_next = READ_HEADER;
                end
            end
            READ_HEADER: begin
                s_payload_ready_next = realign_in_ready;
                if (in_xfer) begin
                    realign_take = 1'b1;
                    hdr_beat_strobe = {{(`IP_RX_HDR_BEATS-1){1'b0}}, 1'b1} << hdr_cnt;
                    hdr_cnt_next = hdr_cnt + 2'd1;
                    // frame ends before any payload byte
                    if (s_payload_last && (hdr_cnt != HDR_LAST || shift_beat.last)) begin
                        err_next.hdr_early = 1'b1;
                        realign_flush = 1'b1;
                        s_payload_ready_next = 1'b0;
                        state_next = IDLE;
                    end else if (hdr_cnt == HDR_LAST) begin
                        if (hdr_unsupported) begin
                            err_next.bad_hdr = 1'b1;
                            state_next = WAIT_LAST;
                        end else begin
                            s_payload_ready_next = skid_ready_early && realign_in_ready;
                            state_next = READ_PAYLOAD;
                        end
                    end
                end
            end
            READ_PAYLOAD: begin
                s_payload_ready_next = skid_ready_early && realign_in_ready;
                int_valid = shift_valid;
                if (fwd) begin
                    realign_take = 1'b1;
                    if (shift_beat.last) begin
                        realign_flush = 1'b1;
                        s_payload_ready_next = 1'b0;
                        state_next = IDLE;
                    end
                end
                // verdict lands in the first payload cycle
                if (csum_done) begin
                    if (csum_ok) begin
                        m_hdr_valid_next = 1'b1;
                    end else begin
                        err_next.bad_csum = 1'b1;
                        int_valid = 1'b0;
                        if (!(fwd && shift_beat.last)) begin
                            s_payload_ready_next = realign_in_ready;
                            state_next = WAIT_LAST;
                        end
                    end
                end
            end
            WAIT_LAST: begin
                // drop beats until end of frame
                s_payload_ready_next = realign_in_ready;
                if (shift_valid) begin
                    realign_take = 1'b1;
                    if (shift_beat.last) begin
                        realign_flush = 1'b1;
                        s_payload_ready_next = 1'b0;
                        state_next = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase

        // next header waits until the current one is taken
        s_hdr_ready_next = (state_next == IDLE) && !m_hdr_valid_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            hdr_cnt <= '0;
            s_hdr_ready <= 1'b0;
            s_payload_ready <= 1'b0;
            m_hdr_valid <= 1'b0;
            err <= '0;
        end else begin
            state <= state_next;
            hdr_cnt <= hdr_cnt_next;
            s_hdr_ready <= s_hdr_ready_next;
            s_payload_ready <= s_payload_ready_next;
            m_hdr_valid <= m_hdr_valid_next;
            err <= err_next;
        end
    end

    assign int_beat = shift_beat;
    assign busy = (state != IDLE);

    // header fields must hold until taken
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid |-> !store_eth && (hdr_beat_strobe == '0));

    a_strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        (state == READ_HEADER) && in_xfer |-> $onehot(hdr_beat_strobe));

endmodule

// ==== hw/ip_rx_pkg.sv ====
package ip_rx_pkg;

    `include "ip_rx_settings.svh"

    // one payload beat, byte 0 in data[7:0]
    typedef struct packed {
        logic [`IP_RX_DATA_W-1:0] data;
        logic [`IP_RX_KEEP_W-1:0] keep;
        logic                     last;
    } axis_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_HEADER,
        READ_PAYLOAD,
        WAIT_LAST
    } rx_state_e;

    // one-cycle error pulses
    typedef struct packed {
        logic hdr_early;
        logic bad_hdr;
        logic bad_csum;
    } rx_err_t;

endpackage

// ==== hw/payload_realign.sv ====
`timescale 1ns/10ps

`include "ip_rx_settings.svh"

module payload_realign
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_payload,
    input  logic       s_payload_valid,
    input  logic       realign_take,
    input  logic       realign_flush,
    output axis_beat_t shift_beat,
    output logic       shift_valid,
    output logic       in_ready
);

    localparam int HALF_W = `IP_RX_DATA_W / 2;
    localparam int HALF_K = `IP_RX_KEEP_W / 2;

    logic [`IP_RX_DATA_W-1:0] save_data;
    logic [`IP_RX_KEEP_W-1:0] save_keep;
    // final input beat still has upper bytes to emit
    logic                     extra;
    logic                     in_has_upper;

    assign in_has_upper = |s_payload.keep[`IP_RX_KEEP_W-1:HALF_K];

    always_comb begin
        // lower half always from the held beat
        shift_beat.data[HALF_W-1:0] = save_data[`IP_RX_DATA_W-1:HALF_W];
        shift_beat.keep[HALF_K-1:0] = save_keep[`IP_RX_KEEP_W-1:HALF_K];
        if (extra) begin
            shift_beat.data[`IP_RX_DATA_W-1:HALF_W] = '0;
            shift_beat.keep[`IP_RX_KEEP_W-1:HALF_K] = '0;
            shift_beat.last = 1'b1;
            shift_valid = 1'b1;
            in_ready = realign_flush;
        end else begin
            shift_beat.data[`IP_RX_DATA_W-1:HALF_W] = s_payload.data[HALF_W-1:0];
            shift_beat.keep[`IP_RX_KEEP_W-1:HALF_K] = s_payload.keep[HALF_K-1:0];
            shift_beat.last = s_payload.last && !in_has_upper;
            shift_valid = s_payload_valid;
            // stall input for the flush beat after last
            in_ready = !(s_payload.last && s_payload_valid && realign_take);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || realign_flush) begin
            extra <= 1'b0;
        end else if (realign_take) begin
            extra <= s_payload.last && in_has_upper;
        end
    end

    always_ff @(posedge clk) begin
        if (realign_take) begin
            save_data <= s_payload.data;
            save_keep <= s_payload.keep;
        end
    end

endmodule

// ==== hw/stream_skid_reg.sv ====
`timescale 1ns/10ps

module stream_skid_reg
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t int_beat,
    input  logic       int_valid,
    output logic       ready_early,
    output logic       ready_int,
    output axis_beat_t m_payload,
    output logic       m_payload_valid,
    input  logic       m_payload_ready
);

    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       int_to_out;
    logic       int_to_temp;
    logic       temp_to_out;

    // ready next cycle unless the temp entry could fill
    assign ready_early = m_payload_ready ||
                         (!temp_valid && (!m_payload_valid || !int_valid));

    always_comb begin
        out_valid_next = m_payload_valid;
        temp_valid_next = temp_valid;
        int_to_out = 1'b0;
        int_to_temp = 1'b0;
        temp_to_out = 1'b0;
        if (ready_int) begin
            if (m_payload_ready || !m_payload_valid) begin
                out_valid_next = int_valid;
                int_to_out = 1'b1;
            end else begin
                temp_valid_next = int_valid;
                int_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_valid <= 1'b0;
            temp_valid <= 1'b0;
            ready_int <= 1'b0;
        end else begin
            m_payload_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_int <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_payload <= int_beat;
        end else if (temp_to_out) begin
            m_payload <= temp_beat;
        end
        if (int_to_temp) begin
            temp_beat <= int_beat;
        end
    end

    a_temp_behind_out: assert property (@(posedge clk) disable iff (rst)
        temp_valid |-> m_payload_valid);

endmodule

// ==== include/ip_rx_settings.svh ====
`ifndef IP_RX_SETTINGS_SVH
`define IP_RX_SETTINGS_SVH

// payload datapath width in bits
`define IP_RX_DATA_W 64

// bytes per payload beat
`define IP_RX_KEEP_W 8

// payload beats carrying the 20-byte IP header
`define IP_RX_HDR_BEATS 3

// only plain IPv4 without options is accepted
`define IP_RX_VERSION 4
`define IP_RX_IHL 5

`endif

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== testbench/tb_ip_eth_rx.sv ====
`timescale 1ns/10ps

module tb_ip_eth_rx
    import eth_ip_pkg::*;
    import ip_rx_pkg::*;
();

    localparam int BEAT_BYTES = 8;
    localparam int IP_HDR_BYTES = 20;
    localparam int NUM_FRAMES = 16;

    // len is the IP payload size, or the whole frame size when trunc is set
    typedef struct packed {
        logic [15:0] len;
        logic        bad_csum;
        logic [1:0]  bad_hdr;
        logic        trunc;
        logic [1:0]  duty;
    } frame_t;

    logic       clk;
    logic       rst;
    logic       s_hdr_valid;
    logic       s_hdr_ready;
    eth_hdr_t   s_hdr;
    logic       s_payload_valid;
    logic       s_payload_ready;
    axis_beat_t s_payload;
    logic       m_hdr_valid;
    logic       m_hdr_ready;
    eth_hdr_t   m_eth;
    ip_hdr_t    m_ip;
    logic       m_payload_valid;
    logic       m_payload_ready;
    axis_beat_t m_payload;
    logic       busy;
    rx_err_t    err;

    frame_t     frames [NUM_FRAMES];
    integer     seed = 32'ha44bd8f4;
    logic [1:0] duty = 2'd0;
    int         limit_cycles = 0;
    eth_hdr_t   cur_eth;
    rx_err_t    exp_err;
    rx_err_t    seen_err = '0;
    logic [7:0] frame_bytes [$];
    axis_beat_t exp_beats [$];
    eth_hdr_t   exp_eth_q [$];
    ip_hdr_t    exp_ip_q [$];

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(10)) i_clk_gen (.clk(clk), .rst(rst));

    ip_eth_rx i_dut (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .s_payload       (s_payload),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_eth           (m_eth),
        .m_ip            (m_ip),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload),
        .busy            (busy),
        .err             (err)
    );

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic pick_ready(input logic [1:0] d);
        logic [31:0] r;
        r = rand_word();
        case (d)
            2'd1: return r[0];
            2'd2: return (r[1:0] == 2'd0);
            2'd3: return (r[1:0] != 2'd0);
            default: return 1'b1;
        endcase
    endfunction

    // wire bytes of one frame plus the expected outputs
    task automatic build_frame(input frame_t f);
        ip_hdr_t      h;
        logic [159:0] hv;
        logic [127:0] wide;
        logic [31:0]  r;
        logic [31:0]  sum;
        axis_beat_t   b;
        int           total;
        int           n;
        int           k;
        wide = {rand_word(), rand_word(), rand_word(), rand_word()};
        cur_eth = wide[111:0];
        cur_eth.eth_type = 16'h0800;
        h.version = (f.bad_hdr == 2'd1) ? 4'd6 : 4'd4;
        h.ihl = (f.bad_hdr == 2'd2) ? 4'd6 : 4'd5;
        h.length = 16'(IP_HDR_BYTES + int'(f.len));
        r = rand_word();
        h.dscp = r[5:0];
        h.ecn = r[7:6];
        h.identification = r[23:8];
        h.ttl = r[31:24];
        r = rand_word();
        h.flags = r[2:0];
        h.frag_offset = r[15:3];
        h.protocol = r[23:16];
        h.src_ip = rand_word();
        h.dest_ip = rand_word();
        h.hdr_checksum = '0;
        // one's complement sum of the ten big-endian header words
        hv = h;
        sum = '0;
        for (k = 0; k < 10; k++) begin
            sum = sum + 32'(hv[159-16*k -: 16]);
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        h.hdr_checksum = ~sum[15:0];
        if (f.bad_csum) begin
            h.hdr_checksum = h.hdr_checksum ^ 16'h0101;
        end
        hv = h;
        total = f.trunc ? int'(f.len) : IP_HDR_BYTES + int'(f.len);
        frame_bytes.delete();
        for (k = 0; k < total; k++) begin
            r = rand_word();
            frame_bytes.push_back((k < IP_HDR_BYTES) ? hv[159-8*k -: 8] : r[7:0]);
        end
        exp_err = '0;
        exp_err.hdr_early = f.trunc;
        exp_err.bad_hdr = !f.trunc && (f.bad_hdr != 2'd0);
        exp_err.bad_csum = !f.trunc && (f.bad_hdr == 2'd0) && f.bad_csum;
        if (exp_err == '0) begin
            exp_eth_q.push_back(cur_eth);
            exp_ip_q.push_back(h);
            // payload from byte 20 repacked from lane 0
            n = total - IP_HDR_BYTES;
            b = '0;
            for (k = 0; k < n; k++) begin
                b.data[8*(k%BEAT_BYTES) +: 8] = frame_bytes[IP_HDR_BYTES+k];
                b.keep[k%BEAT_BYTES] = 1'b1;
                if ((k % BEAT_BYTES == BEAT_BYTES - 1) || (k == n - 1)) begin
                    b.last = (k == n - 1);
                    exp_beats.push_back(b);
                    b = '0;
                end
            end
        end
    endtask

    task automatic send_header();
        s_hdr = cur_eth;
        s_hdr_valid = 1'b1;
        do @(posedge clk); while (!s_hdr_ready);
        #1;
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        axis_beat_t b;
        int         nbeats;
        int         k;
        int         j;
        nbeats = (frame_bytes.size() + BEAT_BYTES - 1) / BEAT_BYTES;
        for (k = 0; k < nbeats; k++) begin
            b = '0;
            for (j = 0; j < BEAT_BYTES; j++) begin
                if (BEAT_BYTES * k + j < frame_bytes.size()) begin
                    b.data[8*j +: 8] = frame_bytes[BEAT_BYTES*k+j];
                    b.keep[j] = 1'b1;
                end
            end
            b.last = (k == nbeats - 1);
            s_payload = b;
            s_payload_valid = 1'b1;
            do @(posedge clk); while (!s_payload_ready);
            #1;
        end
        s_payload_valid = 1'b0;
        s_payload = '0;
    endtask

    // one more edge so the monitor has latched the last pulse
    task automatic wait_idle();
        @(posedge clk);
        #1;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_beat();
        axis_beat_t  e;
        logic [63:0] mask;
        int          j;
        assert (exp_beats.size() != 0) else begin
            $display("payload beat at %0t ns while no beat was expected", $time);
            fail_run();
        end
        e = exp_beats.pop_front();
        mask = '0;
        for (j = 0; j < BEAT_BYTES; j++) begin
            if (e.keep[j]) begin
                mask[8*j +: 8] = 8'hff;
            end
        end
        check_value("m_payload.keep", m_payload.keep, e.keep);
        check_value("m_payload.last", m_payload.last, e.last);
        check_value("m_payload.data", m_payload.data & mask, e.data & mask);
    endtask

    task automatic check_header();
        eth_hdr_t e;
        ip_hdr_t  p;
        assert (exp_ip_q.size() != 0) else begin
            $display("header output at %0t ns while no good frame was pending", $time);
            fail_run();
        end
        e = exp_eth_q.pop_front();
        p = exp_ip_q.pop_front();
        check_value("m_eth", m_eth, e);
        check_value("m_ip.version", m_ip.version, p.version);
        check_value("m_ip.ihl", m_ip.ihl, p.ihl);
        check_value("m_ip.dscp", m_ip.dscp, p.dscp);
        check_value("m_ip.ecn", m_ip.ecn, p.ecn);
        check_value("m_ip.length", m_ip.length, p.length);
        check_value("m_ip.identification", m_ip.identification, p.identification);
        check_value("m_ip.flags", m_ip.flags, p.flags);
        check_value("m_ip.frag_offset", m_ip.frag_offset, p.frag_offset);
        check_value("m_ip.ttl", m_ip.ttl, p.ttl);
        check_value("m_ip.protocol", m_ip.protocol, p.protocol);
        check_value("m_ip.hdr_checksum", m_ip.hdr_checksum, p.hdr_checksum);
        check_value("m_ip.src_ip", m_ip.src_ip, p.src_ip);
        check_value("m_ip.dest_ip", m_ip.dest_ip, p.dest_ip);
    endtask

    // output side monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (m_payload_valid && m_payload_ready) begin
                check_beat();
            end
            if (m_hdr_valid && m_hdr_ready) begin
                check_header();
            end
            seen_err = seen_err | err;
        end
    end

    // output back-pressure
    initial begin
        m_payload_ready = 1'b0;
        m_hdr_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst) begin
                m_payload_ready = pick_ready(duty);
                m_hdr_ready = pick_ready(duty);
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        fail_run();
    end

    initial begin
        int total_bytes;
        int i;
        s_hdr_valid = 1'b0;
        s_hdr = '0;
        s_payload_valid = 1'b0;
        s_payload = '0;
        // len, bad_csum, bad_hdr (1 version, 2 ihl), trunc, duty
        frames = '{
            '{16'd1,   1'b0, 2'd0, 1'b0, 2'd0},
            '{16'd4,   1'b0, 2'd0, 1'b0, 2'd0},
            '{16'd5,   1'b0, 2'd0, 1'b0, 2'd1},
            '{16'd8,   1'b0, 2'd0, 1'b0, 2'd0},
            '{16'd9,   1'b0, 2'd0, 1'b0, 2'd2},
            '{16'd64,  1'b0, 2'd0, 1'b0, 2'd1},
            '{16'd37,  1'b1, 2'd0, 1'b0, 2'd0},
            '{16'd30,  1'b0, 2'd1, 1'b0, 2'd3},
            '{16'd12,  1'b0, 2'd0, 1'b1, 2'd0},
            '{16'd19,  1'b0, 2'd0, 1'b0, 2'd1},
            '{16'd27,  1'b0, 2'd2, 1'b0, 2'd0},
            '{16'd20,  1'b0, 2'd0, 1'b1, 2'd3},
            '{16'd100, 1'b0, 2'd0, 1'b0, 2'd2},
            '{16'd3,   1'b1, 2'd0, 1'b0, 2'd2},
            '{16'd45,  1'b0, 2'd0, 1'b0, 2'd3},
            '{16'd16,  1'b0, 2'd0, 1'b0, 2'd1}
        };
        total_bytes = 0;
        for (i = 0; i < NUM_FRAMES; i++) begin
            total_bytes = total_bytes + IP_HDR_BYTES + int'(frames[i].len);
        end
        // worst case ready duty is one in four
        limit_cycles = 500 + 4 * total_bytes;

        @(negedge rst);
        @(posedge clk);
        #1;
        for (i = 0; i < NUM_FRAMES; i++) begin
            duty = frames[i].duty;
            build_frame(frames[i]);
            seen_err = '0;
            send_header();
            send_payload();
            wait_idle();
            check_value("err", seen_err, exp_err);
        end

        duty = 2'd0;
        while (exp_beats.size() != 0 || exp_ip_q.size() != 0 || busy) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        assert (!busy && !m_payload_valid && !m_hdr_valid) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("outputs still pending at %0t ns after all frames drained", $time);
            fail_run();
        end
    end

endmodule

// ==== vlog.f ====
+incdir+include
hw/eth_ip_pkg.sv
hw/ip_rx_pkg.sv
hw/ip_hdr_capture.sv
hw/ip_hdr_checksum.sv
hw/payload_realign.sv
hw/ip_rx_fsm.sv
hw/stream_skid_reg.sv
hw/ip_eth_rx.sv
testbench/tb_clk_gen.sv
testbench/tb_ip_eth_rx.sv
